/* hdl/rx_dma_pkg.sv */
// Beat, status and FIFO sizing definitions shared by the receive bridge; import where needed
`default_nettype none

package rx_dma_pkg;

   // Longest frame the bridge accepts, in 64-bit beats
   localparam int MAX_FRAME_BEATS = 32;

   // Crossing FIFOs, rx_clk to s2mm_clk
   localparam int DATA_FIFO_DEPTH = 512;
   localparam int INFO_FIFO_DEPTH = 256;

   // Output FIFOs, s2mm_clk only
   localparam int GOOD_FIFO_DEPTH = 512;
   localparam int CTRL_FIFO_DEPTH = 64;

   // A frame started below these levels always fits
   localparam int DATA_AFULL_LEVEL = DATA_FIFO_DEPTH - MAX_FRAME_BEATS;
   localparam int GOOD_AFULL_LEVEL = GOOD_FIFO_DEPTH - MAX_FRAME_BEATS;

   // One word per frame, small margin is enough
   localparam int INFO_AFULL_LEVEL = INFO_FIFO_DEPTH - 4;
   localparam int CTRL_AFULL_LEVEL = CTRL_FIFO_DEPTH - 4;

   // Data beat from the MAC, also the rxd output beat
   typedef struct packed {
      logic        last;
      logic [7:0]  keep;
      logic [63:0] data;
   } rx_beat_t;

   // Status beat on rxs
   typedef struct packed {
      logic        last;
      logic [3:0]  keep;
      logic [31:0] data;
   } sts_beat_t;

   // Payload of a status beat
   typedef struct packed {
      logic [15:0] seq;
      logic [15:0] len;
   } frame_status_t;

endpackage

`default_nettype wire

/* hdl/async_fifo.sv */
// Dual-clock FWFT FIFO with Gray pointers; instantiate per clock crossing with width and depth
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
   parameter int WIDTH       = 8,
   parameter int DEPTH       = 16,
   parameter int AFULL_LEVEL = 12
) (
   // Write side
   input  wire logic             wclk,
   input  wire logic             rst,
   input  wire logic [WIDTH-1:0] wdata,
   input  wire logic             winc,
   output logic                  w_afull,
   // Read side
   input  wire logic             rclk,
   output logic      [WIDTH-1:0] rdata,
   input  wire logic             rinc,
   output logic                  rempty
);

   // Pointers carry one extra wrap bit
   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];

   logic [AW:0] wbin, wbin_nxt, wgray;
   logic [AW:0] rq1_gray, rq2_gray, w_level;
   logic [AW:0] rbin, rbin_nxt, rgray;
   logic [AW:0] wq1_gray, wq2_gray;
   logic        wr, rd;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Fill level seen from the write clock, pessimistic by the sync delay
   assign w_level  = wbin - gray2bin(rq2_gray);
   assign w_afull  = w_level >= (AW + 1)'(AFULL_LEVEL);
   assign wr       = winc & ~w_level[AW];
   assign wbin_nxt = wbin + (AW + 1)'(wr);

   always_ff @(posedge wclk) begin
      if (wr) begin
         mem[wbin[AW-1:0]] <= wdata;
      end
   end

   // Write pointer and read pointer sync
   always_ff @(posedge wclk) begin
      if (rst) begin
         wbin     <= '0;
         wgray    <= '0;
         rq1_gray <= '0;
         rq2_gray <= '0;
      end else begin
         wbin     <= wbin_nxt;
         wgray    <= bin2gray(wbin_nxt);
         rq1_gray <= rgray;
         rq2_gray <= rq1_gray;
      end
   end

   // Empty once the synced write pointer catches up
   assign rempty   = rgray == wq2_gray;
   assign rd       = rinc & ~rempty;
   assign rbin_nxt = rbin + (AW + 1)'(rd);
   // Head word, no read latency
   assign rdata    = mem[rbin[AW-1:0]];

   always_ff @(posedge rclk) begin
      if (rst) begin
         rbin     <= '0;
         rgray    <= '0;
         wq1_gray <= '0;
         wq2_gray <= '0;
      end else begin
         rbin     <= rbin_nxt;
         rgray    <= bin2gray(rbin_nxt);
         wq1_gray <= wgray;
         wq2_gray <= wq1_gray;
      end
   end

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
// Single-clock FWFT FIFO with programmable almost-full; instantiate for each output stream
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH       = 8,
   parameter int DEPTH       = 16,
   parameter int AFULL_LEVEL = 12
) (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic [WIDTH-1:0] din,
   input  wire logic             wr_en,
   input  wire logic             rd_en,
   output logic      [WIDTH-1:0] dout,
   output logic                  empty,
   output logic                  afull
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wptr, rptr;
   logic [AW:0]      count;
   logic             wr, rd;

   // Ignore writes when full, reads when empty
   assign wr    = wr_en & (count != (AW + 1)'(DEPTH));
   assign rd    = rd_en & ~empty;
   assign empty = count == '0;
   assign afull = count >= (AW + 1)'(AFULL_LEVEL);
   assign dout  = mem[rptr];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (wr) begin
            wptr <= wptr + 1'b1;
         end
         if (rd) begin
            rptr <= rptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (wr && !rd) begin
            count <= count + 1'b1;
         end else if (rd && !wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/rx_frame_writer.sv */
// MAC-side writer in rx_clk; pushes frames into the crossing FIFOs or drops whole frames
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer (
   input  wire logic                 rx_clk,
   input  wire logic                 rst,
   // MAC beats, no back-pressure
   input  wire rx_dma_pkg::rx_beat_t rx_beat,
   input  wire logic                 rx_valid,
   input  wire logic                 rx_good,
   // Crossing FIFO status
   input  wire logic                 data_fifo_afull,
   input  wire logic                 info_fifo_afull,
   // Crossing FIFO writes
   output rx_dma_pkg::rx_beat_t      data_fifo_wdata,
   output logic                      data_fifo_wren,
   output logic                      info_fifo_wdata,
   output logic                      info_fifo_wren,
   output logic                      rx_drop
);

   logic in_frame;
   logic dropping;
   logic first_beat;
   logic drop_now;

   // First beat is any valid beat outside a frame
   assign first_beat = rx_valid & ~in_frame;

   // Decide at the first beat, hold until the last
   assign drop_now = first_beat ? (data_fifo_afull | info_fifo_afull) : dropping;

   assign rx_drop         = first_beat & drop_now;
   assign data_fifo_wdata = rx_beat;
   assign data_fifo_wren  = rx_valid & ~drop_now;
   // One good flag per kept frame
   assign info_fifo_wdata = rx_good;
   assign info_fifo_wren  = rx_valid & rx_beat.last & ~drop_now;

   always_ff @(posedge rx_clk) begin
      if (rst) begin
         in_frame <= 1'b0;
         dropping <= 1'b0;
      end else if (rx_valid) begin
         // Single-beat frame never enters
         in_frame <= ~rx_beat.last;
         dropping <= drop_now;
      end
   end

endmodule

`default_nettype wire

/* hdl/ifm_fifo.sv */
// Interface FIFO block; crossing data and info FIFOs plus the rxd and rxs output FIFOs
`timescale 1ns/1ps
`default_nettype none

module ifm_fifo (
   input  wire logic                  rx_clk,
   input  wire logic                  rst,
   input  wire logic                  s2mm_clk,
   // Data crossing
   input  wire rx_dma_pkg::rx_beat_t  data_fifo_wdata,
   input  wire logic                  data_fifo_wren,
   output logic                       data_fifo_afull,
   output rx_dma_pkg::rx_beat_t       data_fifo_rdata,
   input  wire logic                  data_fifo_rden,
   output logic                       data_fifo_empty,
   // Good flag crossing
   input  wire logic                  info_fifo_wdata,
   input  wire logic                  info_fifo_wren,
   output logic                       info_fifo_afull,
   output logic                       info_fifo_rdata,
   input  wire logic                  info_fifo_rden,
   output logic                       info_fifo_empty,
   // Filtered data and status
   input  wire rx_dma_pkg::rx_beat_t  good_fifo_wdata,
   input  wire logic                  good_fifo_wren,
   output logic                       good_fifo_afull,
   input  wire rx_dma_pkg::sts_beat_t ctrl_fifo_wdata,
   input  wire logic                  ctrl_fifo_wren,
   output logic                       ctrl_fifo_afull,
   // Output streams
   output rx_dma_pkg::rx_beat_t       rxd_beat,
   output logic                       rxd_tvalid,
   input  wire logic                  rxd_tready,
   output rx_dma_pkg::sts_beat_t      rxs_beat,
   output logic                       rxs_tvalid,
   input  wire logic                  rxs_tready
);

   import rx_dma_pkg::*;

   logic good_fifo_empty;
   logic good_fifo_rden;
   logic ctrl_fifo_empty;
   logic ctrl_fifo_rden;

   // Frame beats, rx_clk to s2mm_clk
   async_fifo #(
      .WIDTH      ($bits(rx_beat_t)),
      .DEPTH      (DATA_FIFO_DEPTH),
      .AFULL_LEVEL(DATA_AFULL_LEVEL)
   ) data_fifo (
      .wclk   (rx_clk),
      .rst    (rst),
      .wdata  (data_fifo_wdata),
      .winc   (data_fifo_wren),
      .w_afull(data_fifo_afull),
      .rclk   (s2mm_clk),
      .rdata  (data_fifo_rdata),
      .rinc   (data_fifo_rden),
      .rempty (data_fifo_empty)
   );

   // Per-frame good flag
   async_fifo #(
      .WIDTH      (1),
      .DEPTH      (INFO_FIFO_DEPTH),
      .AFULL_LEVEL(INFO_AFULL_LEVEL)
   ) info_fifo (
      .wclk   (rx_clk),
      .rst    (rst),
      .wdata  (info_fifo_wdata),
      .winc   (info_fifo_wren),
      .w_afull(info_fifo_afull),
      .rclk   (s2mm_clk),
      .rdata  (info_fifo_rdata),
      .rinc   (info_fifo_rden),
      .rempty (info_fifo_empty)
   );

   // rxd pops the head on handshake
   assign rxd_tvalid     = ~good_fifo_empty;
   assign good_fifo_rden = rxd_tvalid & rxd_tready;

   sync_fifo #(
      .WIDTH      ($bits(rx_beat_t)),
      .DEPTH      (GOOD_FIFO_DEPTH),
      .AFULL_LEVEL(GOOD_AFULL_LEVEL)
   ) good_fifo (
      .clk  (s2mm_clk),
      .rst  (rst),
      .din  (good_fifo_wdata),
      .wr_en(good_fifo_wren),
      .rd_en(good_fifo_rden),
      .dout (rxd_beat),
      .empty(good_fifo_empty),
      .afull(good_fifo_afull)
   );

   // Same scheme for rxs
   assign rxs_tvalid     = ~ctrl_fifo_empty;
   assign ctrl_fifo_rden = rxs_tvalid & rxs_tready;

   sync_fifo #(
      .WIDTH      ($bits(sts_beat_t)),
      .DEPTH      (CTRL_FIFO_DEPTH),
      .AFULL_LEVEL(CTRL_AFULL_LEVEL)
   ) ctrl_fifo (
      .clk  (s2mm_clk),
      .rst  (rst),
      .din  (ctrl_fifo_wdata),
      .wr_en(ctrl_fifo_wren),
      .rd_en(ctrl_fifo_rden),
      .dout (rxs_beat),
      .empty(ctrl_fifo_empty),
      .afull(ctrl_fifo_afull)
   );

endmodule

`default_nettype wire

/* hdl/rx_frame_filter.sv */
// Frame filter in s2mm_clk; drops bad frames and forwards good ones with a status beat
`timescale 1ns/1ps
`default_nettype none

module rx_frame_filter (
   input  wire logic                  s2mm_clk,
   input  wire logic                  rst,
   // Crossing FIFO heads
   input  wire rx_dma_pkg::rx_beat_t  data_fifo_rdata,
   input  wire logic                  data_fifo_empty,
   output logic                       data_fifo_rden,
   input  wire logic                  info_fifo_rdata,
   input  wire logic                  info_fifo_empty,
   output logic                       info_fifo_rden,
   // Output FIFO writes
   output rx_dma_pkg::rx_beat_t       good_fifo_wdata,
   output logic                       good_fifo_wren,
   input  wire logic                  good_fifo_afull,
   output rx_dma_pkg::sts_beat_t      ctrl_fifo_wdata,
   output logic                       ctrl_fifo_wren,
   input  wire logic                  ctrl_fifo_afull
);

   import rx_dma_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PASS,
      ST_DISCARD
   } state_t;

   state_t        state;
   logic          start;
   logic          beat;
   logic          sts_pend;
   logic [15:0]   len;
   logic [15:0]   seq;
   frame_status_t status;

   // Room for a whole frame and its status beat
   assign start = (state == ST_IDLE) & ~info_fifo_empty & ~good_fifo_afull & ~ctrl_fifo_afull;
   assign info_fifo_rden = start;

   // One beat per cycle while data is there
   assign beat           = (state != ST_IDLE) & ~data_fifo_empty;
   assign data_fifo_rden = beat;

   // Only good frames reach rxd
   assign good_fifo_wdata = data_fifo_rdata;
   assign good_fifo_wren  = beat & (state == ST_PASS);

   // Status beat from the finished frame
   assign status.seq           = seq;
   assign status.len           = len;
   assign ctrl_fifo_wdata.last = 1'b1;
   assign ctrl_fifo_wdata.keep = 4'hf;
   assign ctrl_fifo_wdata.data = status;
   assign ctrl_fifo_wren       = sts_pend;

   always_ff @(posedge s2mm_clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         sts_pend <= 1'b0;
         len      <= '0;
         seq      <= '0;
      end else begin
         sts_pend <= 1'b0;
         // Count delivered frames as the status goes out
         if (sts_pend) begin
            seq <= seq + 1'b1;
         end
         case (state)
            ST_IDLE: begin
               if (start) begin
                  len   <= '0;
                  state <= info_fifo_rdata ? ST_PASS : ST_DISCARD;
               end
            end
            ST_PASS: begin
               if (beat) begin
                  if (data_fifo_rdata.last) begin
                     // Partial last beat counts its keep bits
                     len      <= len + 16'($countones(data_fifo_rdata.keep));
                     sts_pend <= 1'b1;
                     state    <= ST_IDLE;
                  end else begin
                     len <= len + 16'd8;
                  end
               end
            end
            ST_DISCARD: begin
               // Bad frame, pop without writing
               if (beat && data_fifo_rdata.last) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/rx_dma_ingress.sv */
// Receive bridge top level; MAC beats in on rx_clk, rxd and rxs streams out on s2mm_clk
`timescale 1ns/1ps
`default_nettype none

module rx_dma_ingress (
   input  wire logic                  rx_clk,
   input  wire logic                  s2mm_clk,
   input  wire logic                  rst,
   // MAC side
   input  wire rx_dma_pkg::rx_beat_t  rx_beat,
   input  wire logic                  rx_valid,
   input  wire logic                  rx_good,
   output logic                       rx_drop,
   // DMA side
   output rx_dma_pkg::rx_beat_t       rxd_beat,
   output logic                       rxd_tvalid,
   input  wire logic                  rxd_tready,
   output rx_dma_pkg::sts_beat_t      rxs_beat,
   output logic                       rxs_tvalid,
   input  wire logic                  rxs_tready
);

   // Writer to crossing FIFOs
   rx_dma_pkg::rx_beat_t  data_fifo_wdata;
   logic                  data_fifo_wren;
   logic                  data_fifo_afull;
   logic                  info_fifo_wdata;
   logic                  info_fifo_wren;
   logic                  info_fifo_afull;
   // Crossing FIFOs to filter
   rx_dma_pkg::rx_beat_t  data_fifo_rdata;
   logic                  data_fifo_rden;
   logic                  data_fifo_empty;
   logic                  info_fifo_rdata;
   logic                  info_fifo_rden;
   logic                  info_fifo_empty;
   // Filter to output FIFOs
   rx_dma_pkg::rx_beat_t  good_fifo_wdata;
   logic                  good_fifo_wren;
   logic                  good_fifo_afull;
   rx_dma_pkg::sts_beat_t ctrl_fifo_wdata;
   logic                  ctrl_fifo_wren;
   logic                  ctrl_fifo_afull;

   rx_frame_writer writer0 (
      .rx_clk         (rx_clk),
      .rst            (rst),
      .rx_beat        (rx_beat),
      .rx_valid       (rx_valid),
      .rx_good        (rx_good),
      .data_fifo_afull(data_fifo_afull),
      .info_fifo_afull(info_fifo_afull),
      .data_fifo_wdata(data_fifo_wdata),
      .data_fifo_wren (data_fifo_wren),
      .info_fifo_wdata(info_fifo_wdata),
      .info_fifo_wren (info_fifo_wren),
      .rx_drop        (rx_drop)
   );

   ifm_fifo ifm0 (
      .rx_clk         (rx_clk),
      .rst            (rst),
      .s2mm_clk       (s2mm_clk),
      .data_fifo_wdata(data_fifo_wdata),
      .data_fifo_wren (data_fifo_wren),
      .data_fifo_afull(data_fifo_afull),
      .data_fifo_rdata(data_fifo_rdata),
      .data_fifo_rden (data_fifo_rden),
      .data_fifo_empty(data_fifo_empty),
      .info_fifo_wdata(info_fifo_wdata),
      .info_fifo_wren (info_fifo_wren),
      .info_fifo_afull(info_fifo_afull),
      .info_fifo_rdata(info_fifo_rdata),
      .info_fifo_rden (info_fifo_rden),
      .info_fifo_empty(info_fifo_empty),
      .good_fifo_wdata(good_fifo_wdata),
      .good_fifo_wren (good_fifo_wren),
      .good_fifo_afull(good_fifo_afull),
      .ctrl_fifo_wdata(ctrl_fifo_wdata),
      .ctrl_fifo_wren (ctrl_fifo_wren),
      .ctrl_fifo_afull(ctrl_fifo_afull),
      .rxd_beat       (rxd_beat),
      .rxd_tvalid     (rxd_tvalid),
      .rxd_tready     (rxd_tready),
      .rxs_beat       (rxs_beat),
      .rxs_tvalid     (rxs_tvalid),
      .rxs_tready     (rxs_tready)
   );

   rx_frame_filter filter0 (
      .s2mm_clk       (s2mm_clk),
      .rst            (rst),
      .data_fifo_rdata(data_fifo_rdata),
      .data_fifo_empty(data_fifo_empty),
      .data_fifo_rden (data_fifo_rden),
      .info_fifo_rdata(info_fifo_rdata),
      .info_fifo_empty(info_fifo_empty),
      .info_fifo_rden (info_fifo_rden),
      .good_fifo_wdata(good_fifo_wdata),
      .good_fifo_wren (good_fifo_wren),
      .good_fifo_afull(good_fifo_afull),
      .ctrl_fifo_wdata(ctrl_fifo_wdata),
      .ctrl_fifo_wren (ctrl_fifo_wren),
      .ctrl_fifo_afull(ctrl_fifo_afull)
   );

endmodule

`default_nettype wire

/* verification/rx_dma_ingress_tb.sv */
// Self-checking testbench for rx_dma_ingress; run the file list with this module as top
`timescale 1ns/1ps
`default_nettype none

module rx_dma_ingress_tb;

   import rx_dma_pkg::*;

   // One line of the stimulus file
   typedef struct {
      int         beats;
      logic [7:0] keep;
      logic       good;
      int         phase;
      int         len;
   } frame_t;

   logic          rx_clk;
   logic          s2mm_clk;
   logic          rst;
   rx_beat_t      rx_beat;
   logic          rx_valid;
   logic          rx_good;
   logic          rx_drop;
   rx_beat_t      rxd_beat;
   logic          rxd_tvalid;
   logic          rxd_tready;
   sts_beat_t     rxs_beat;
   logic          rxs_tvalid;
   logic          rxs_tready;

   frame_t        frames [$];
   rx_beat_t      data_sb [$];
   frame_status_t status_sb [$];
   int            next_seq;
   int            drops_phase1;
   // Ready is random in mode 0, low in mode 1 and high in mode 2
   int            ready_mode;
   int            cycle_count;
   int            cycle_limit;

   rx_dma_ingress dut0 (
      .rx_clk    (rx_clk),
      .s2mm_clk  (s2mm_clk),
      .rst       (rst),
      .rx_beat   (rx_beat),
      .rx_valid  (rx_valid),
      .rx_good   (rx_good),
      .rx_drop   (rx_drop),
      .rxd_beat  (rxd_beat),
      .rxd_tvalid(rxd_tvalid),
      .rxd_tready(rxd_tready),
      .rxs_beat  (rxs_beat),
      .rxs_tvalid(rxs_tvalid),
      .rxs_tready(rxs_tready)
   );

   always #5 rx_clk = ~rx_clk;

   // s2mm_clk lags by 3 ns
   always begin
      #3;
      forever #5 s2mm_clk = ~s2mm_clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic check_beat(input rx_beat_t got, input rx_beat_t exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t: rxd last=%0b keep=%02h data=%016h, exp %0b %02h %016h",
                            $time, got.last, got.keep, got.data, exp.last, exp.keep, exp.data));
      end
   endtask

   task automatic check_status(input frame_status_t got, input frame_status_t exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t: rxs seq=%0d len=%0d, expected seq=%0d len=%0d",
                            $time, got.seq, got.len, exp.seq, exp.len));
      end
   endtask

   task automatic load_frames(output int total_beats);
      int    fd;
      int    n_beats, n_keep, n_good, n_phase, n_len;
      string line;
      frame_t f;
      total_beats = 0;
      fd = $fopen("verification/rx_frames_stimulus.txt", "r");
      if (fd == 0) begin
         fail_run("Could not open the stimulus file verification/rx_frames_stimulus.txt");
      end
      while (!$feof(fd)) begin
         // Comment and blank lines do not scan as five fields
         if ($fgets(line, fd) != 0 &&
             $sscanf(line, "%d %h %d %d %d", n_beats, n_keep, n_good, n_phase, n_len) == 5) begin
            if (n_beats < 1 || n_beats > MAX_FRAME_BEATS) begin
               fail_run($sformatf("Stimulus line has an illegal beat count of %0d", n_beats));
            end
            f.beats = n_beats;
            f.keep  = 8'(n_keep);
            f.good  = 1'(n_good);
            f.phase = n_phase;
            f.len   = n_len;
            frames.push_back(f);
            total_beats += n_beats;
         end
      end
      $fclose(fd);
   endtask

   // Drives one frame and fills the scoreboards for kept good frames
   task automatic send_frame(input frame_t f);
      rx_beat_t      b;
      logic          dropped;
      frame_status_t s;
      dropped = 1'b0;
      for (int i = 0; i < f.beats; i++) begin
         // Occasional idle cycle even inside a frame
         if ($urandom_range(3) == 0) begin
            rx_valid <= 1'b0;
            @(posedge rx_clk);
         end
         b.last = (i == f.beats - 1);
         b.keep = b.last ? f.keep : 8'hff;
         b.data = {$urandom, $urandom};
         rx_beat  <= b;
         rx_valid <= 1'b1;
         // Good flag is junk except on the last beat
         rx_good  <= b.last ? f.good : 1'($urandom_range(1));
         @(posedge rx_clk);
         // rx_drop still shows the beat taken at this edge
         if (i == 0) begin
            dropped = rx_drop;
            if (dropped && f.phase == 0) begin
               fail_run($sformatf("ERROR at %0t: rx_drop high in phase 0", $time));
            end
         end else if (rx_drop) begin
            fail_run($sformatf("ERROR at %0t: rx_drop high after the first beat", $time));
         end
         if (!dropped && f.good) begin
            data_sb.push_back(b);
         end
      end
      if (dropped) begin
         drops_phase1++;
      end else if (f.good) begin
         s.seq = 16'(next_seq);
         s.len = 16'(f.len);
         status_sb.push_back(s);
         next_seq++;
      end
   endtask

   task automatic wait_drained();
      while (data_sb.size() != 0 || status_sb.size() != 0) begin
         @(posedge rx_clk);
      end
   endtask

   always @(posedge s2mm_clk) begin
      if (ready_mode == 0) begin
         rxd_tready <= 1'($urandom_range(1));
         rxs_tready <= 1'($urandom_range(1));
      end else begin
         rxd_tready <= (ready_mode == 2);
         rxs_tready <= (ready_mode == 2);
      end
   end

   // Output monitors against the scoreboards
   always @(posedge s2mm_clk) begin
      if (!rst) begin
         if (rxd_tvalid && rxd_tready) begin
            if (data_sb.size() == 0) begin
               fail_run($sformatf("ERROR at %0t: unexpected beat on rxd", $time));
            end else begin
               check_beat(rxd_beat, data_sb.pop_front());
            end
         end
         if (rxs_tvalid && rxs_tready) begin
            if (rxs_beat.last !== 1'b1 || rxs_beat.keep !== 4'hf) begin
               fail_run($sformatf("ERROR at %0t: rxs beat last=%0b keep=%01h",
                                  $time, rxs_beat.last, rxs_beat.keep));
            end else if (status_sb.size() == 0) begin
               fail_run($sformatf("ERROR at %0t: unexpected beat on rxs", $time));
            end else begin
               check_status(frame_status_t'(rxs_beat.data), status_sb.pop_front());
            end
         end
      end
   end

   always @(posedge rx_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         fail_run($sformatf("Timeout, the run went past %0d rx_clk cycles", cycle_limit));
      end
   end

   initial begin
      int total_beats;
      rx_clk       = 1'b0;
      s2mm_clk     = 1'b0;
      rst          = 1'b1;
      rx_beat      = '0;
      rx_valid     = 1'b0;
      rx_good      = 1'b0;
      rxd_tready   = 1'b0;
      rxs_tready   = 1'b0;
      next_seq     = 0;
      drops_phase1 = 0;
      ready_mode   = 0;
      cycle_count  = 0;
      cycle_limit  = 2000;
      void'($urandom(88));
      load_frames(total_beats);
      cycle_limit  = total_beats * 20 + 2000;
      repeat (4) @(posedge rx_clk);
      rst <= 1'b0;
      @(posedge rx_clk);
      foreach (frames[k]) begin
         // Phase 1 starts from empty FIFOs and stalls both streams
         if (frames[k].phase == 1 && ready_mode == 0) begin
            wait_drained();
            ready_mode = 1;
         end
         send_frame(frames[k]);
      end
      rx_valid <= 1'b0;
      @(posedge rx_clk);
      ready_mode = 2;
      wait_drained();
      // Settling window for any stray beat
      repeat (64) @(posedge s2mm_clk);
      if (rxd_tvalid || rxs_tvalid) begin
         fail_run("Beats were left at the outputs after all expected frames arrived");
      end else if (drops_phase1 == 0) begin
         fail_run("No frame was dropped while both streams were stalled in phase 1");
      end else begin
         $display("Delivered %0d frames, dropped %0d in phase 1", next_seq, drops_phase1);
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verification/rx_frames_stimulus.txt */
# beats  last_keep(hex)  good  phase  expected_len(bytes)
# phase 0 random ready, phase 1 stalled outputs until all frames are sent
1  01 1 0 1
1  ff 1 0 8
2  03 1 0 10
3  0f 0 0 20
4  ff 1 0 32
5  07 1 0 35
8  1f 1 0 61
2  ff 0 0 16
12 3f 1 0 94
16 7f 1 0 127
1  0f 0 0 4
32 ff 1 0 256
7  01 1 0 49
20 3f 0 0 158
32 ff 1 1 256
32 ff 1 1 256
32 0f 1 1 252
4  ff 0 1 32
32 ff 1 1 256
31 ff 1 1 248
32 ff 1 1 256
32 03 1 1 250
32 ff 1 1 256
30 7f 1 1 239
32 ff 1 1 256
32 ff 1 1 256
4  ff 0 1 32
32 ff 1 1 256
32 0f 1 1 252
32 ff 1 1 256
32 ff 1 1 256
31 ff 1 1 248
32 ff 1 1 256
32 ff 1 1 256
32 03 1 1 250
32 ff 1 1 256
32 ff 1 1 256
4  ff 0 1 32
32 ff 1 1 256
30 7f 1 1 239
32 ff 1 1 256
32 ff 1 1 256
32 ff 1 1 256
32 0f 1 1 252
32 ff 1 1 256
31 ff 1 1 248
32 ff 1 1 256
4  ff 0 1 32
32 ff 1 1 256
32 ff 1 1 256
32 03 1 1 250
32 ff 1 1 256
32 ff 1 1 256
32 ff 1 1 256

/* verilog.f */
hdl/rx_dma_pkg.sv
hdl/async_fifo.sv
hdl/sync_fifo.sv
hdl/rx_frame_writer.sv
hdl/ifm_fifo.sv
hdl/rx_frame_filter.sv
hdl/rx_dma_ingress.sv
verification/rx_dma_ingress_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = rx_dma_ingress_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
